/* Makefile */
# Verilator build and run of the CHIP-8 core testbench

SRCS := $(wildcard hdl/*.sv tb/*.sv include/*.svh)
BIN  := obj_dir/Vchip8_core_tb

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): vlog.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module chip8_core_tb -f vlog.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/chip8_alu.sv */
// Registered 8-bit ALU for loads, arithmetic, shifts and skip compares
// Result appears the cycle after start and holds until the next start
`timescale 1ns/1ps
`default_nettype none

module chip8_alu (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire chip8_pkg::alu_op_e  op,
    input  wire chip8_pkg::byte_t    vx,
    input  wire chip8_pkg::byte_t    vy,
    input  wire chip8_pkg::byte_t    kk,
    output chip8_pkg::alu_res_t      res
);
    import chip8_pkg::*;

    alu_res_t nxt;
    logic     carry;
    byte_t    sum_y;

    assign {carry, sum_y} = vx + vy;

    always_comb begin
        nxt = '0;
        case (op)
            alu_pass_kk: nxt.value = kk;
            alu_add_kk:  nxt.value = vx + kk;
            alu_pass_y:  nxt.value = vy;
            alu_or:      nxt.value = vx | vy;
            alu_and:     nxt.value = vx & vy;
            alu_xor:     nxt.value = vx ^ vy;
            // VF = carry out
            alu_add_y: begin
                nxt.value   = sum_y;
                nxt.flag    = byte_t'(carry);
                nxt.flag_we = 1'b1;
            end
            // VF = not borrow, strict greater than
            alu_sub_xy: begin
                nxt.value   = vx - vy;
                nxt.flag    = byte_t'(vx > vy);
                nxt.flag_we = 1'b1;
            end
            alu_sub_yx: begin
                nxt.value   = vy - vx;
                nxt.flag    = byte_t'(vy > vx);
                nxt.flag_we = 1'b1;
            end
            // Shifted-out bit goes to VF
            alu_shr: begin
                nxt.value   = vx >> 1;
                nxt.flag    = byte_t'(vx[0]);
                nxt.flag_we = 1'b1;
            end
            alu_shl: begin
                nxt.value   = vx << 1;
                nxt.flag    = byte_t'(vx[7]);
                nxt.flag_we = 1'b1;
            end
            alu_cmp_eq_kk: nxt.cond = (vx == kk);
            alu_cmp_ne_kk: nxt.cond = (vx != kk);
            alu_cmp_eq_y:  nxt.cond = (vx == vy);
            alu_cmp_ne_y:  nxt.cond = (vx != vy);
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (start) begin
            res <= nxt;
        end
    end

    a_flag_ops: assert property (@(posedge clk) disable iff (rst)
        start |=> (!res.flag_we ||
                   ($past(op) inside {alu_add_y, alu_sub_xy, alu_shr, alu_sub_yx, alu_shl})))
        else $error("VF write from an operation that does not set it");

endmodule

`default_nettype wire

/* hdl/chip8_control.sv */
// Four-state instruction sequencer and decoder of the CHIP-8 core
// Drives fetch, the datapath strobes and the retire record
`timescale 1ns/1ps
`default_nettype none

module chip8_control (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire chip8_pkg::instr_t  instr,
    input  wire chip8_pkg::addr_t   pc,
    input  wire chip8_pkg::addr_t   next_pc,
    input  wire chip8_pkg::alu_res_t alu_res,
    output logic                    fetch,
    output logic                    retire,
    output chip8_pkg::retire_t      retire_info,
    output chip8_pkg::reg_idx_t     rd_x,
    output chip8_pkg::reg_idx_t     rd_y,
    output logic                    alu_start,
    output chip8_pkg::alu_op_e      alu_op,
    output chip8_pkg::byte_t        kk,
    output logic                    wr_en,
    output logic                    pc_update,
    output chip8_pkg::pc_op_e       pc_op,
    output chip8_pkg::addr_t        target
);
    import chip8_pkg::*;

    // One-hot state bits
    localparam int st_fetch = 0;
    localparam int st_dec   = 1;
    localparam int st_exec  = 2;
    localparam int st_wb    = 3;

    logic [3:0] state;
    logic       started;
    instr_t     ir;
    logic       wr_dec;

    // Hold in fetch for the first cycle out of reset so fetch stays low
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= 4'b0001;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (started) begin
                state <= {state[2:0], state[3]};
            end
        end
    end

    // Instruction word is valid on the port during decode
    always_ff @(posedge clk) begin
        if (state[st_dec]) begin
            ir <= instr;
        end
    end

    assign fetch     = started && state[st_fetch];
    assign alu_start = state[st_exec];
    assign wr_en     = state[st_wb] && wr_dec;
    assign pc_update = state[st_wb];
    assign retire    = state[st_wb];

    assign rd_x   = ir.x;
    assign rd_y   = ir.y;
    assign kk     = {ir.y, ir.n};
    assign target = {ir.x, ir.y, ir.n};

    always_comb begin
        // Unknown opcodes fall through as no-ops
        alu_op = alu_pass_kk;
        pc_op  = pc_inc;
        wr_dec = 1'b0;
        case (ir.opcode)
            4'h0: begin
                if (ir == 16'h00EE) begin
                    pc_op = pc_ret;
                end else if (ir != 16'h00E0) begin
                    pc_op = pc_jump;
                end
            end
            4'h1: pc_op = pc_jump;
            4'h2: pc_op = pc_call;
            4'h3: begin
                alu_op = alu_cmp_eq_kk;
                pc_op  = pc_skip_if;
            end
            4'h4: begin
                alu_op = alu_cmp_ne_kk;
                pc_op  = pc_skip_if;
            end
            4'h5: begin
                if (ir.n == 4'h0) begin
                    alu_op = alu_cmp_eq_y;
                    pc_op  = pc_skip_if;
                end
            end
            4'h6: begin
                alu_op = alu_pass_kk;
                wr_dec = 1'b1;
            end
            4'h7: begin
                alu_op = alu_add_kk;
                wr_dec = 1'b1;
            end
            4'h8: begin
                wr_dec = 1'b1;
                case (ir.n)
                    4'h0: alu_op = alu_pass_y;
                    4'h1: alu_op = alu_or;
                    4'h2: alu_op = alu_and;
                    4'h3: alu_op = alu_xor;
                    4'h4: alu_op = alu_add_y;
                    4'h5: alu_op = alu_sub_xy;
                    4'h6: alu_op = alu_shr;
                    4'h7: alu_op = alu_sub_yx;
                    4'hE: alu_op = alu_shl;
                    default: wr_dec = 1'b0;
                endcase
            end
            4'h9: begin
                if (ir.n == 4'h0) begin
                    alu_op = alu_cmp_ne_y;
                    pc_op  = pc_skip_if;
                end
            end
            4'hB: pc_op = pc_jump_v0;
            default: ;
        endcase
    end

    // pc still holds the address of the retiring instruction
    always_comb begin
        retire_info          = '0;
        retire_info.addr     = pc;
        retire_info.next_pc  = next_pc;
        if (wr_dec) begin
            retire_info.wr_en  = 1'b1;
            retire_info.wr_idx = ir.x;
            retire_info.wr_val = alu_res.value;
            if (alu_res.flag_we) begin
                retire_info.flag_we  = 1'b1;
                retire_info.flag_val = alu_res.flag;
            end
        end
    end

    a_one_state: assert property (@(posedge clk) disable iff (rst) $onehot(state))
        else $error("sequencer not in exactly one state");

    // Retire closes the instruction that fetch opened three cycles earlier
    a_retire_wb: assert property (@(posedge clk) disable iff (rst)
        retire |-> ($past(alu_start) && $past(fetch, 3)))
        else $error("retire outside writeback");

endmodule

`default_nettype wire

/* hdl/chip8_core.sv */
// Top level of the CHIP-8 instruction core
// Sequencer plus register file, ALU and PC unit, one instruction per 4 cycles
`timescale 1ns/1ps
`default_nettype none

module chip8_core #(
    parameter chip8_pkg::addr_t prog_start  = 12'h200,
    parameter int               stack_depth = 16
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire chip8_pkg::instr_t  instr,
    output logic                    fetch,
    output chip8_pkg::addr_t        fetch_addr,
    output logic                    retire,
    output chip8_pkg::retire_t      retire_info
);
    import chip8_pkg::*;

    reg_idx_t rd_x;
    reg_idx_t rd_y;
    byte_t    vx;
    byte_t    vy;
    byte_t    v0;
    byte_t    kk;
    logic     alu_start;
    alu_op_e  alu_op;
    alu_res_t alu_res;
    logic     wr_en;
    logic     pc_update;
    pc_op_e   pc_op;
    addr_t    target;
    addr_t    next_pc;

    chip8_control u_control (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .pc          (fetch_addr),
        .next_pc     (next_pc),
        .alu_res     (alu_res),
        .fetch       (fetch),
        .retire      (retire),
        .retire_info (retire_info),
        .rd_x        (rd_x),
        .rd_y        (rd_y),
        .alu_start   (alu_start),
        .alu_op      (alu_op),
        .kk          (kk),
        .wr_en       (wr_en),
        .pc_update   (pc_update),
        .pc_op       (pc_op),
        .target      (target)
    );

    chip8_reg_file u_reg_file (
        .clk   (clk),
        .rst   (rst),
        .rd_x  (rd_x),
        .rd_y  (rd_y),
        .vx    (vx),
        .vy    (vy),
        .v0    (v0),
        .wr_en (wr_en),
        .res   (alu_res)
    );

    chip8_alu u_alu (
        .clk   (clk),
        .rst   (rst),
        .start (alu_start),
        .op    (alu_op),
        .vx    (vx),
        .vy    (vy),
        .kk    (kk),
        .res   (alu_res)
    );

    // PC doubles as the program port address
    chip8_pc_unit #(
        .prog_start  (prog_start),
        .stack_depth (stack_depth)
    ) u_pc_unit (
        .clk     (clk),
        .rst     (rst),
        .update  (pc_update),
        .op      (pc_op),
        .target  (target),
        .v0      (v0),
        .cond    (alu_res.cond),
        .pc      (fetch_addr),
        .next_pc (next_pc)
    );

endmodule

`default_nettype wire

/* hdl/chip8_pc_unit.sv */
// Program counter and return stack of the CHIP-8 core
// next_pc is combinational and loads into pc on the update strobe
`timescale 1ns/1ps
`default_nettype none

module chip8_pc_unit #(
    parameter chip8_pkg::addr_t prog_start  = 12'h200,
    parameter int               stack_depth = 16
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               update,
    input  wire chip8_pkg::pc_op_e  op,
    input  wire chip8_pkg::addr_t   target,
    input  wire chip8_pkg::byte_t   v0,
    input  wire logic               cond,
    output chip8_pkg::addr_t        pc,
    output chip8_pkg::addr_t        next_pc
);
    import chip8_pkg::*;

    localparam int idx_w = $clog2(stack_depth);
    // One more bit so a full stack is distinct from an empty one
    localparam int sp_w  = $clog2(stack_depth + 1);

    addr_t           stack_mem [stack_depth];
    logic [sp_w-1:0] sp;
    addr_t           pc_plus2;
    addr_t           top;

    assign pc_plus2 = pc + addr_t'(2);
    assign top      = stack_mem[idx_w'(sp - 1'b1)];

    always_comb begin
        case (op)
            pc_inc:     next_pc = pc_plus2;
            pc_skip_if: next_pc = cond ? pc + addr_t'(4) : pc_plus2;
            pc_jump:    next_pc = target;
            pc_jump_v0: next_pc = target + addr_t'(v0);
            pc_call:    next_pc = target;
            pc_ret:     next_pc = top;
            default:    next_pc = pc_plus2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= prog_start;
            sp <= '0;
        end else if (update) begin
            pc <= next_pc;
            if (op == pc_call) begin
                sp <= sp + 1'b1;
            end else if (op == pc_ret) begin
                sp <= sp - 1'b1;
            end
        end
    end

    // Return address is the word after the call
    always_ff @(posedge clk) begin
        if (update && op == pc_call) begin
            stack_mem[idx_w'(sp)] <= pc_plus2;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (update && op == pc_call) |-> (sp < sp_w'(stack_depth)))
        else $error("call with the return stack full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (update && op == pc_ret) |-> (sp != '0))
        else $error("return with the return stack empty");

endmodule

`default_nettype wire

/* hdl/chip8_pkg.sv */
// Shared widths, instruction fields and record types of the CHIP-8 core
// Imported by every RTL module and by the testbench
`default_nettype none

package chip8_pkg;

    // Program address space and register file geometry
    localparam int addr_w   = 12;
    localparam int data_w   = 8;
    localparam int num_regs = 16;
    localparam int vf_idx   = 15;

    typedef logic [addr_w-1:0]           addr_t;
    typedef logic [data_w-1:0]           byte_t;
    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

    // One 16-bit instruction word, kk is {y, n} and nnn is {x, y, n}
    typedef struct packed {
        logic [3:0] opcode;
        reg_idx_t   x;
        reg_idx_t   y;
        logic [3:0] n;
    } instr_t;

    // Data operations first, then the compares used by skips
    typedef enum logic [3:0] {
        alu_pass_kk,
        alu_add_kk,
        alu_pass_y,
        alu_or,
        alu_and,
        alu_xor,
        alu_add_y,
        alu_sub_xy,
        alu_shr,
        alu_sub_yx,
        alu_shl,
        alu_cmp_eq_kk,
        alu_cmp_ne_kk,
        alu_cmp_eq_y,
        alu_cmp_ne_y
    } alu_op_e;

    typedef enum logic [2:0] {
        pc_inc,
        pc_skip_if,
        pc_jump,
        pc_jump_v0,
        pc_call,
        pc_ret
    } pc_op_e;

    typedef struct packed {
        byte_t value;
        byte_t flag;
        logic  flag_we;
        logic  cond;
    } alu_res_t;

    // One retired instruction, fields are zero when their write is off
    typedef struct packed {
        addr_t    addr;
        logic     wr_en;
        reg_idx_t wr_idx;
        byte_t    wr_val;
        logic     flag_we;
        byte_t    flag_val;
        addr_t    next_pc;
    } retire_t;

endpackage

`default_nettype wire

/* hdl/chip8_reg_file.sv */
// Sixteen 8-bit V registers with asynchronous reads
// Writes value to Vx and then the flag to VF at the end of writeback
`timescale 1ns/1ps
`default_nettype none

module chip8_reg_file (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire chip8_pkg::reg_idx_t  rd_x,
    input  wire chip8_pkg::reg_idx_t  rd_y,
    output chip8_pkg::byte_t          vx,
    output chip8_pkg::byte_t          vy,
    output chip8_pkg::byte_t          v0,
    input  wire logic                 wr_en,
    input  wire chip8_pkg::alu_res_t  res
);
    import chip8_pkg::*;

    byte_t regs [num_regs];

    assign vx = regs[rd_x];
    assign vy = regs[rd_y];
    // Bnnn offset
    assign v0 = regs[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_x] <= res.value;
            // Later assignment wins when x is VF
            if (res.flag_we) begin
                regs[vf_idx] <= res.flag;
            end
        end
    end

endmodule

`default_nettype wire

/* include/chip8_prog_table.svh */
// Test program for the CHIP-8 core, one row per retired instruction in retire order
// Columns: word, address, Vx write, x, value, VF write, VF value, next PC
// Skipped words are not listed and read back as the fill pattern

localparam int num_steps = 38;
// Words from 0x200 up to 0x282
localparam int prog_size = 66;

localparam step_t steps [num_steps] = '{
    // Loads and adds, 7xkk wraps with no flag
    '{16'h6006, 12'h200, 1'b1, 4'h0, 8'h06, 1'b0, 8'h00, 12'h202},
    '{16'h6A3C, 12'h202, 1'b1, 4'hA, 8'h3C, 1'b0, 8'h00, 12'h204},
    '{16'h7AF0, 12'h204, 1'b1, 4'hA, 8'h2C, 1'b0, 8'h00, 12'h206},
    '{16'h61C8, 12'h206, 1'b1, 4'h1, 8'hC8, 1'b0, 8'h00, 12'h208},
    '{16'h6250, 12'h208, 1'b1, 4'h2, 8'h50, 1'b0, 8'h00, 12'h20A},
    // Moves and logic ops
    '{16'h8310, 12'h20A, 1'b1, 4'h3, 8'hC8, 1'b0, 8'h00, 12'h20C},
    '{16'h8321, 12'h20C, 1'b1, 4'h3, 8'hD8, 1'b0, 8'h00, 12'h20E},
    '{16'h8322, 12'h20E, 1'b1, 4'h3, 8'h50, 1'b0, 8'h00, 12'h210},
    '{16'h8313, 12'h210, 1'b1, 4'h3, 8'h98, 1'b0, 8'h00, 12'h212},
    // Add with carry, both subtracts and both shifts
    '{16'h8124, 12'h212, 1'b1, 4'h1, 8'h18, 1'b1, 8'h01, 12'h214},
    '{16'h8425, 12'h214, 1'b1, 4'h4, 8'hB0, 1'b1, 8'h00, 12'h216},
    '{16'h8215, 12'h216, 1'b1, 4'h2, 8'h38, 1'b1, 8'h01, 12'h218},
    '{16'h6587, 12'h218, 1'b1, 4'h5, 8'h87, 1'b0, 8'h00, 12'h21A},
    '{16'h8506, 12'h21A, 1'b1, 4'h5, 8'h43, 1'b1, 8'h01, 12'h21C},
    '{16'h850E, 12'h21C, 1'b1, 4'h5, 8'h86, 1'b1, 8'h00, 12'h21E},
    '{16'h830E, 12'h21E, 1'b1, 4'h3, 8'h30, 1'b1, 8'h01, 12'h220},
    '{16'h8237, 12'h220, 1'b1, 4'h2, 8'hF8, 1'b1, 8'h00, 12'h222},
    '{16'h8627, 12'h222, 1'b1, 4'h6, 8'hF8, 1'b1, 8'h01, 12'h224},
    // VF as destination, the flag overwrites the sum and V7 reads it back
    '{16'h8F54, 12'h224, 1'b1, 4'hF, 8'h87, 1'b1, 8'h00, 12'h226},
    '{16'h87F0, 12'h226, 1'b1, 4'h7, 8'h00, 1'b0, 8'h00, 12'h228},
    // Skips, taken then not taken or the reverse
    '{16'h3006, 12'h228, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h22C},
    '{16'h3005, 12'h22C, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h22E},
    '{16'h4006, 12'h22E, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h230},
    '{16'h4007, 12'h230, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h234},
    '{16'h5260, 12'h234, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h238},
    '{16'h5120, 12'h238, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h23A},
    '{16'h9120, 12'h23A, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h23E},
    '{16'h9260, 12'h23E, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h240},
    // Jumps, Bnnn adds V0 = 06
    '{16'h1246, 12'h240, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h246},
    '{16'hB250, 12'h246, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h256},
    '{16'h0260, 12'h256, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h260},
    // Calls two deep and their returns
    '{16'h2270, 12'h260, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h270},
    '{16'h2280, 12'h270, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h280},
    '{16'h6E42, 12'h280, 1'b1, 4'hE, 8'h42, 1'b0, 8'h00, 12'h282},
    '{16'h00EE, 12'h282, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h272},
    '{16'h00EE, 12'h272, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h262},
    // Unsupported opcode, then park on a jump to itself
    '{16'hF307, 12'h262, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h264},
    '{16'h1264, 12'h264, 1'b0, 4'h0, 8'h00, 1'b0, 8'h00, 12'h264}
};

/* tb/chip8_core_tb.sv */
// Testbench for the CHIP-8 core, models the program port and checks every retire
// Program words and expected retire records come from the included table
`timescale 1ns/1ps
`default_nettype none

module chip8_core_tb;
    import chip8_pkg::*;

    // One program word with the retire record it must produce
    typedef struct packed {
        logic [15:0] word;
        addr_t       addr;
        logic        wr_en;
        reg_idx_t    wr_idx;
        byte_t       wr_val;
        logic        flag_we;
        byte_t       flag_val;
        addr_t       next_pc;
    } step_t;

    `include "chip8_prog_table.svh"

    // Cycles allowed for any single wait
    localparam int wait_limit = 20;

    logic    clk;
    logic    rst;
    instr_t  instr;
    logic    fetch;
    addr_t   fetch_addr;
    logic    retire;
    retire_t retire_info;

    logic [15:0] prog_mem [prog_size];
    int          errors   = 0;
    int          timeouts = 0;
    int          checked  = 0;
    int          fetch_idx;

    // Timing monitor state, counted in falling edges
    int    cycle       = 0;
    int    last_fetch  = 0;
    int    last_retire = 0;
    bit    seen_retire = 1'b0;
    addr_t expect_fetch;

    chip8_core #(
        .prog_start  (12'h200),
        .stack_depth (16)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .fetch       (fetch),
        .fetch_addr  (fetch_addr),
        .retire      (retire),
        .retire_info (retire_info)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic log_failure(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic check_field(input int step, input string field,
                               input logic [15:0] got, input logic [15:0] want);
        assert (got == want) else
            log_failure($sformatf("step %0d %s = 0x%0h, expected 0x%0h", step, field, got, want));
    endtask

    // Field by field so a mismatch names the field
    task automatic check_retire(input int i);
        step_t s;
        s = steps[i];
        check_field(i, "addr", 16'(retire_info.addr), 16'(s.addr));
        check_field(i, "wr_en", 16'(retire_info.wr_en), 16'(s.wr_en));
        check_field(i, "wr_idx", 16'(retire_info.wr_idx), 16'(s.wr_idx));
        check_field(i, "wr_val", 16'(retire_info.wr_val), 16'(s.wr_val));
        check_field(i, "flag_we", 16'(retire_info.flag_we), 16'(s.flag_we));
        check_field(i, "flag_val", 16'(retire_info.flag_val), 16'(s.flag_val));
        check_field(i, "next_pc", 16'(retire_info.next_pc), 16'(s.next_pc));
        checked++;
    endtask

    // Always steps at least one edge, so a retire is never seen twice
    task automatic wait_for_retire(output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < wait_limit) begin
            @(negedge clk);
            n++;
            seen = (retire === 1'b1);
        end
        if (!seen) begin
            timeouts++;
            $display("TIMEOUT at %0t: no retire within %0d cycles", $time, wait_limit);
        end
    endtask

    task automatic wait_for_fetch(output int n, output bit seen);
        n    = 0;
        seen = 1'b0;
        while (!seen && n < wait_limit) begin
            @(negedge clk);
            n++;
            seen = (fetch === 1'b1);
        end
        if (!seen) begin
            timeouts++;
            $display("TIMEOUT at %0t: no fetch within %0d cycles", $time, wait_limit);
        end
    endtask

    // Program port, the word for fetch_addr goes out on the falling edge of fetch
    always @(negedge clk) begin
        if (fetch === 1'b1) begin
            fetch_idx = (int'(fetch_addr) - 'h200) / 2;
            assert (fetch_idx >= 0 && fetch_idx < prog_size) else begin
                errors++;
                $display("ERROR at %0t: fetch from 0x%h lies outside the program",
                         $time, fetch_addr);
            end
            if (fetch_idx >= 0 && fetch_idx < prog_size) begin
                instr = prog_mem[fetch_idx];
            end
        end
    end

    // Fetch to retire is 3 cycles, retire to next fetch is 1
    always @(negedge clk) begin
        cycle++;
        if (retire === 1'b1) begin
            assert (cycle - last_fetch == 3) else
                log_failure($sformatf("retire %0d cycles after fetch", cycle - last_fetch));
            last_retire  = cycle;
            expect_fetch = retire_info.next_pc;
            seen_retire  = 1'b1;
        end
        if (fetch === 1'b1) begin
            if (seen_retire) begin
                assert (cycle - last_retire == 1) else
                    log_failure($sformatf("fetch %0d cycles after retire", cycle - last_retire));
                // The retired next_pc is where the core fetches next
                assert (fetch_addr == expect_fetch) else
                    log_failure($sformatf("fetch_addr 0x%h, retired next_pc 0x%h",
                                          fetch_addr, expect_fetch));
            end
            last_fetch = cycle;
        end
    end

    initial begin
        int n;
        bit ok;
        rst   = 1'b1;
        instr = '0;
        // Unlisted words hold a no-op that carries its own address
        for (int a = 0; a < prog_size; a++) begin
            prog_mem[a] = {4'hF, addr_t'(12'h200 + 2 * a)};
        end
        for (int i = 0; i < num_steps; i++) begin
            prog_mem[(int'(steps[i].addr) - 'h200) / 2] = steps[i].word;
        end
        repeat (5) begin
            @(negedge clk);
            assert (fetch === 1'b0 && retire === 1'b0) else
                log_failure("fetch or retire high during reset");
        end
        rst = 1'b0;
        wait_for_fetch(n, ok);
        if (ok) begin
            assert (n == 1) else
                log_failure($sformatf("first fetch %0d cycles after reset", n));
            assert (fetch_addr == 12'h200) else
                log_failure($sformatf("first fetch_addr 0x%h", fetch_addr));
            for (int i = 0; i < num_steps; i++) begin
                wait_for_retire(ok);
                if (!ok) begin
                    break;
                end
                check_retire(i);
            end
        end
        $display("errors: %0d, timeouts: %0d, retires checked: %0d of %0d",
                 errors, timeouts, checked, num_steps);
        if (errors == 0 && timeouts == 0 && checked == num_steps) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hdl/chip8_pkg.sv
hdl/chip8_control.sv
hdl/chip8_alu.sv
hdl/chip8_reg_file.sv
hdl/chip8_pc_unit.sv
hdl/chip8_core.sv
tb/chip8_core_tb.sv
